//--- design/core_pkg.sv
package core_pkg;

    // width of an integer register index
    localparam int REG_ADDR_W = 5;

    // width of a CSR address
    localparam int CSR_ADDR_W = 12;

    // machine CSR addresses
    localparam logic [CSR_ADDR_W-1:0] CSR_MSTATUS = 12'h300;
    localparam logic [CSR_ADDR_W-1:0] CSR_MTVEC   = 12'h305;
    localparam logic [CSR_ADDR_W-1:0] CSR_MEPC    = 12'h341;
    localparam logic [CSR_ADDR_W-1:0] CSR_MCAUSE  = 12'h342;

    // memory operation of an item
    typedef enum logic [2:0] {
        LOAD_NONE = 3'd0,
        LOAD_LB   = 3'd1,
        LOAD_LBU  = 3'd2,
        LOAD_LH   = 3'd3,
        LOAD_LHU  = 3'd4,
        LOAD_LW   = 3'd5
    } load_op_t;

    // CSR action of an item
    typedef enum logic [2:0] {
        CSR_NONE  = 3'd0,
        CSR_WRITE = 3'd1,
        CSR_SET   = 3'd2,
        CSR_CLEAR = 3'd3,
        CSR_ECALL = 3'd4
    } csr_op_t;

endpackage

//--- design/wb_bus_if.sv
`timescale 1ns/1ps

interface wb_bus_if
    import core_pkg::*;
#(
    parameter int DATA_LEN = 32
) ();

    // single-cycle strobe, all other fields qualified by it
    logic                  valid;
    logic                  wd;
    logic [REG_ADDR_W-1:0] wreg;
    logic [DATA_LEN-1:0]   wdata;
    csr_op_t               csr_op;
    logic [CSR_ADDR_W-1:0] csr_addr;
    logic [DATA_LEN-1:0]   csr_wdata;
    logic [DATA_LEN-1:0]   csr_mcause;
    logic                  ebreak;
    logic                  fencei;

    modport producer (
        output valid, wd, wreg, wdata,
        output csr_op, csr_addr, csr_wdata, csr_mcause,
        output ebreak, fencei
    );

    modport consumer (
        input valid, wd, wreg, wdata,
        input csr_op, csr_addr, csr_wdata, csr_mcause,
        input ebreak, fencei
    );

endinterface

//--- design/csr_write_if.sv
`timescale 1ns/1ps

interface csr_write_if
    import core_pkg::*;
#(
    parameter int DATA_LEN = 32
) ();

    // any op other than CSR_NONE is a request for the next edge
    csr_op_t               op;
    logic [CSR_ADDR_W-1:0] addr;
    logic [DATA_LEN-1:0]   wdata;
    logic [DATA_LEN-1:0]   mcause;

    modport requester (
        output op, addr, wdata, mcause
    );

    modport responder (
        input op, addr, wdata, mcause
    );

endinterface

//--- design/mem_result_stage.sv
`timescale 1ns/1ps

module mem_result_stage
    import core_pkg::*;
#(
    parameter int DATA_LEN = 32
) (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  valid_i,
    input  logic                  wd_i,
    input  logic [REG_ADDR_W-1:0] wreg_i,
    input  logic [DATA_LEN-1:0]   alu_result_i,
    input  load_op_t              load_op_i,
    input  logic [DATA_LEN-1:0]   mem_rdata_i,
    input  csr_op_t               csr_op_i,
    input  logic [CSR_ADDR_W-1:0] csr_addr_i,
    input  logic [DATA_LEN-1:0]   csr_wdata_i,
    input  logic [DATA_LEN-1:0]   csr_mcause_i,
    input  logic                  ebreak_i,
    input  logic                  fencei_i,
    wb_bus_if.producer            wb_o
);

    logic [7:0]          load_byte;
    logic [15:0]         load_half;
    logic [DATA_LEN-1:0] result;

    // lane select from the low address bits
    assign load_byte = mem_rdata_i[{alu_result_i[1:0], 3'b000} +: 8];
    assign load_half = mem_rdata_i[{alu_result_i[1], 4'b0000} +: 16];

    always_comb begin
        case (load_op_i)
            LOAD_LB:  result = {{(DATA_LEN-8){load_byte[7]}}, load_byte};
            LOAD_LBU: result = {{(DATA_LEN-8){1'b0}}, load_byte};
            LOAD_LH:  result = {{(DATA_LEN-16){load_half[15]}}, load_half};
            LOAD_LHU: result = {{(DATA_LEN-16){1'b0}}, load_half};
            LOAD_LW:  result = mem_rdata_i;
            // not a load, alu result goes through
            default:  result = alu_result_i;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            wb_o.valid <= 1'b0;
        end else begin
            wb_o.valid <= valid_i;
        end
    end

    // payload, only meaningful alongside valid
    always_ff @(posedge clock) begin
        wb_o.wd         <= wd_i;
        wb_o.wreg       <= wreg_i;
        wb_o.wdata      <= result;
        wb_o.csr_op     <= csr_op_i;
        wb_o.csr_addr   <= csr_addr_i;
        wb_o.csr_wdata  <= csr_wdata_i;
        wb_o.csr_mcause <= csr_mcause_i;
        wb_o.ebreak     <= ebreak_i;
        wb_o.fencei     <= fencei_i;
    end

    // misaligned loads are trapped upstream and never reach this stage
    a_half_aligned: assert property (
        @(posedge clock) disable iff (reset)
        (valid_i && (load_op_i inside {LOAD_LH, LOAD_LHU})) |-> !alu_result_i[0]
    ) else $error("halfword load at odd address %h", alu_result_i);

    a_word_aligned: assert property (
        @(posedge clock) disable iff (reset)
        (valid_i && load_op_i == LOAD_LW) |-> (alu_result_i[1:0] == 2'b00)
    ) else $error("word load at unaligned address %h", alu_result_i);

endmodule

//--- design/writeback_stage.sv
`timescale 1ns/1ps

module writeback_stage
    import core_pkg::*;
#(
    parameter int DATA_LEN = 32
) (
    input  logic                  clock,
    input  logic                  reset,
    wb_bus_if.consumer            wb_i,
    output logic                  rf_we_o,
    output logic [REG_ADDR_W-1:0] rf_waddr_o,
    output logic [DATA_LEN-1:0]   rf_wdata_o,
    csr_write_if.requester        csr_o,
    output logic                  flush_o,
    output logic                  halt_o
);

    // control, masked with valid
    always_ff @(posedge clock) begin
        if (reset) begin
            rf_we_o  <= 1'b0;
            csr_o.op <= CSR_NONE;
            flush_o  <= 1'b0;
            halt_o   <= 1'b0;
        end else begin
            // x0 writes dropped here
            rf_we_o  <= wb_i.valid & wb_i.wd & (wb_i.wreg != '0);
            csr_o.op <= wb_i.valid ? wb_i.csr_op : CSR_NONE;
            // one-cycle pulse toward fetch
            flush_o  <= wb_i.valid & wb_i.fencei;
            // sticky until reset
            halt_o   <= halt_o | (wb_i.valid & wb_i.ebreak);
        end
    end

    always_ff @(posedge clock) begin
        rf_waddr_o   <= wb_i.wreg;
        rf_wdata_o   <= wb_i.wdata;
        csr_o.addr   <= wb_i.csr_addr;
        csr_o.wdata  <= wb_i.csr_wdata;
        csr_o.mcause <= wb_i.csr_mcause;
    end

    // the regfile also ignores x0, but nothing should ever ask for it
    a_no_x0_write: assert property (
        @(posedge clock) disable iff (reset)
        rf_we_o |-> (rf_waddr_o != '0)
    ) else $error("register write enabled with x0 as target");

endmodule

//--- design/int_regfile.sv
`timescale 1ns/1ps

module int_regfile
    import core_pkg::*;
#(
    parameter int DATA_LEN = 32
) (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  we_i,
    input  logic [REG_ADDR_W-1:0] waddr_i,
    input  logic [DATA_LEN-1:0]   wdata_i,
    input  logic [REG_ADDR_W-1:0] raddr_i,
    output logic [DATA_LEN-1:0]   rdata_o
);

    localparam int NUM_REGS = 2 ** REG_ADDR_W;

    // x1..x31, x0 has no storage
    logic [DATA_LEN-1:0] regs [1:NUM_REGS-1];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // combinational read
    always_comb begin
        if (raddr_i == '0) begin
            rdata_o = '0;
        end else begin
            rdata_o = regs[raddr_i];
        end
    end

endmodule

//--- design/csr_file.sv
`timescale 1ns/1ps

module csr_file
    import core_pkg::*;
#(
    parameter int DATA_LEN = 32
) (
    input  logic                  clock,
    input  logic                  reset,
    csr_write_if.responder        csr_i,
    input  logic [CSR_ADDR_W-1:0] raddr_i,
    output logic [DATA_LEN-1:0]   rdata_o
);

    logic [DATA_LEN-1:0] mstatus;
    logic [DATA_LEN-1:0] mtvec;
    logic [DATA_LEN-1:0] mepc;
    logic [DATA_LEN-1:0] mcause;
    logic [DATA_LEN-1:0] cur_value;
    logic [DATA_LEN-1:0] new_value;

    // current value of the CSR being written
    always_comb begin
        case (csr_i.addr)
            CSR_MSTATUS: cur_value = mstatus;
            CSR_MTVEC:   cur_value = mtvec;
            CSR_MEPC:    cur_value = mepc;
            CSR_MCAUSE:  cur_value = mcause;
            default:     cur_value = '0;
        endcase
    end

    always_comb begin
        case (csr_i.op)
            CSR_WRITE: new_value = csr_i.wdata;
            CSR_SET:   new_value = cur_value | csr_i.wdata;
            CSR_CLEAR: new_value = cur_value & ~csr_i.wdata;
            default:   new_value = cur_value;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            mstatus <= '0;
            mtvec   <= '0;
            mepc    <= '0;
            mcause  <= '0;
        end else if (csr_i.op == CSR_ECALL) begin
            // cause comes with the request, address unused
            mcause <= csr_i.mcause;
        end else if (csr_i.op != CSR_NONE) begin
            case (csr_i.addr)
                CSR_MSTATUS: mstatus <= new_value;
                CSR_MTVEC:   mtvec   <= new_value;
                CSR_MEPC:    mepc    <= new_value;
                CSR_MCAUSE:  mcause  <= new_value;
                // unknown address is ignored
                default: ;
            endcase
        end
    end

    // read port, unknown addresses read zero
    always_comb begin
        case (raddr_i)
            CSR_MSTATUS: rdata_o = mstatus;
            CSR_MTVEC:   rdata_o = mtvec;
            CSR_MEPC:    rdata_o = mepc;
            CSR_MCAUSE:  rdata_o = mcause;
            default:     rdata_o = '0;
        endcase
    end

    // op originates from the execute stage encoding, two stages back
    a_op_defined: assert property (
        @(posedge clock) disable iff (reset)
        (csr_i.op != CSR_NONE) |->
            (csr_i.op inside {CSR_WRITE, CSR_SET, CSR_CLEAR, CSR_ECALL})
    ) else $error("undefined CSR op %0d", csr_i.op);

endmodule

//--- design/core_backend_top.sv
`timescale 1ns/1ps

module core_backend_top
    import core_pkg::*;
#(
    parameter int DATA_LEN = 32
) (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  valid_i,
    input  logic                  wd_i,
    input  logic [REG_ADDR_W-1:0] wreg_i,
    input  logic [DATA_LEN-1:0]   alu_result_i,
    input  load_op_t              load_op_i,
    input  logic [DATA_LEN-1:0]   mem_rdata_i,
    input  csr_op_t               csr_op_i,
    input  logic [CSR_ADDR_W-1:0] csr_addr_i,
    input  logic [DATA_LEN-1:0]   csr_wdata_i,
    input  logic [DATA_LEN-1:0]   csr_mcause_i,
    input  logic                  ebreak_i,
    input  logic                  fencei_i,
    input  logic [REG_ADDR_W-1:0] rs_addr_i,
    output logic [DATA_LEN-1:0]   rs_data_o,
    input  logic [CSR_ADDR_W-1:0] csr_raddr_i,
    output logic [DATA_LEN-1:0]   csr_rdata_o,
    output logic                  flush_o,
    output logic                  halt_o
);

    logic                  rf_we;
    logic [REG_ADDR_W-1:0] rf_waddr;
    logic [DATA_LEN-1:0]   rf_wdata;

    wb_bus_if #(.DATA_LEN(DATA_LEN)) wb_bus ();
    csr_write_if #(.DATA_LEN(DATA_LEN)) csr_bus ();

    // memory-result stage, first register
    mem_result_stage #(.DATA_LEN(DATA_LEN)) i_mem_result_stage (
        .clock        (clock),
        .reset        (reset),
        .valid_i      (valid_i),
        .wd_i         (wd_i),
        .wreg_i       (wreg_i),
        .alu_result_i (alu_result_i),
        .load_op_i    (load_op_i),
        .mem_rdata_i  (mem_rdata_i),
        .csr_op_i     (csr_op_i),
        .csr_addr_i   (csr_addr_i),
        .csr_wdata_i  (csr_wdata_i),
        .csr_mcause_i (csr_mcause_i),
        .ebreak_i     (ebreak_i),
        .fencei_i     (fencei_i),
        .wb_o         (wb_bus.producer)
    );

    // writeback stage, second register
    writeback_stage #(.DATA_LEN(DATA_LEN)) i_writeback_stage (
        .clock      (clock),
        .reset      (reset),
        .wb_i       (wb_bus.consumer),
        .rf_we_o    (rf_we),
        .rf_waddr_o (rf_waddr),
        .rf_wdata_o (rf_wdata),
        .csr_o      (csr_bus.requester),
        .flush_o    (flush_o),
        .halt_o     (halt_o)
    );

    int_regfile #(.DATA_LEN(DATA_LEN)) i_int_regfile (
        .clock   (clock),
        .reset   (reset),
        .we_i    (rf_we),
        .waddr_i (rf_waddr),
        .wdata_i (rf_wdata),
        .raddr_i (rs_addr_i),
        .rdata_o (rs_data_o)
    );

    csr_file #(.DATA_LEN(DATA_LEN)) i_csr_file (
        .clock   (clock),
        .reset   (reset),
        .csr_i   (csr_bus.responder),
        .raddr_i (csr_raddr_i),
        .rdata_o (csr_rdata_o)
    );

endmodule

//--- tests/core_backend_tb.sv
`timescale 1ns/1ps

module core_backend_tb
    import core_pkg::*;
();

    localparam int DATA_LEN    = 32;
    localparam int NUM_ROWS    = 26;
    localparam int NUM_RAND    = 24;
    localparam int CYCLE_LIMIT = NUM_ROWS * 4 + NUM_RAND * 4 + 50;
    localparam logic [31:0] LOAD_WORD = 32'h8a7f_c301;

    typedef struct {
        string       name;
        bit          wd;
        logic [4:0]  wreg;
        logic [31:0] alu;
        load_op_t    lop;
        logic [31:0] mem;
        csr_op_t     cop;
        logic [11:0] caddr;
        logic [31:0] cwdata;
        logic [31:0] cause;
        bit          ebreak;
        bit          fencei;
        bit          probe_csr;
        logic [11:0] probe;
        logic [31:0] exp;
    } row_t;

    logic                clock;
    logic                reset;
    logic                valid_i;
    logic                wd_i;
    logic [4:0]          wreg_i;
    logic [31:0]         alu_result_i;
    load_op_t            load_op_i;
    logic [31:0]         mem_rdata_i;
    csr_op_t             csr_op_i;
    logic [11:0]         csr_addr_i;
    logic [31:0]         csr_wdata_i;
    logic [31:0]         csr_mcause_i;
    logic                ebreak_i;
    logic                fencei_i;
    logic [4:0]          rs_addr_i;
    logic [31:0]         rs_data_o;
    logic [11:0]         csr_raddr_i;
    logic [31:0]         csr_rdata_o;
    logic                flush_o;
    logic                halt_o;

    row_t        rows [NUM_ROWS];
    int          row_count;
    int          data_errors;
    int          ctrl_errors;
    int          cycle_count;
    bit          halt_exp;
    logic [31:0] lcg_state;

    core_backend_top #(.DATA_LEN(DATA_LEN)) i_dut (
        .clock        (clock),
        .reset        (reset),
        .valid_i      (valid_i),
        .wd_i         (wd_i),
        .wreg_i       (wreg_i),
        .alu_result_i (alu_result_i),
        .load_op_i    (load_op_i),
        .mem_rdata_i  (mem_rdata_i),
        .csr_op_i     (csr_op_i),
        .csr_addr_i   (csr_addr_i),
        .csr_wdata_i  (csr_wdata_i),
        .csr_mcause_i (csr_mcause_i),
        .ebreak_i     (ebreak_i),
        .fencei_i     (fencei_i),
        .rs_addr_i    (rs_addr_i),
        .rs_data_o    (rs_data_o),
        .csr_raddr_i  (csr_raddr_i),
        .csr_rdata_o  (csr_rdata_o),
        .flush_o      (flush_o),
        .halt_o       (halt_o)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // run limit
    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] next_random(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // reference for load lane selection and extension
    function automatic logic [31:0] extend_load(input load_op_t op, input logic [31:0] data,
                                                input logic [1:0] off);
        logic [31:0] shifted;
        logic [7:0]  b;
        logic [15:0] h;
        shifted = data >> (8 * off);
        b = shifted[7:0];
        h = shifted[15:0];
        case (op)
            LOAD_LB:  return {{24{b[7]}}, b};
            LOAD_LBU: return {24'h0, b};
            LOAD_LH:  return {{16{h[15]}}, h};
            LOAD_LHU: return {16'h0, h};
            default:  return data;
        endcase
    endfunction

    function automatic row_t alu_row(input string name, input bit wd, input logic [4:0] wreg,
                                     input logic [31:0] value, input logic [4:0] probe,
                                     input logic [31:0] exp);
        row_t r;
        r = '{name, wd, wreg, value, LOAD_NONE, 32'h0, CSR_NONE, 12'h0, 32'h0, 32'h0,
              1'b0, 1'b0, 1'b0, {7'h0, probe}, exp};
        return r;
    endfunction

    function automatic row_t load_row(input string name, input load_op_t op,
                                      input logic [31:0] addr, input logic [31:0] data,
                                      input logic [4:0] wreg, input logic [31:0] exp);
        row_t r;
        r = alu_row(name, 1'b1, wreg, addr, wreg, exp);
        r.lop = op;
        r.mem = data;
        return r;
    endfunction

    function automatic row_t csr_row(input string name, input csr_op_t op,
                                     input logic [11:0] addr, input logic [31:0] wdata,
                                     input logic [31:0] cause, input logic [11:0] probe,
                                     input logic [31:0] exp);
        row_t r;
        r = alu_row(name, 1'b0, 5'd0, 32'h0, 5'd0, exp);
        r.cop = op;
        r.caddr = addr;
        r.cwdata = wdata;
        r.cause = cause;
        r.probe_csr = 1'b1;
        r.probe = probe;
        return r;
    endfunction

    task automatic add_row(input row_t r);
        rows[row_count] = r;
        row_count = row_count + 1;
    endtask

    task automatic build_table();
        row_t r;
        add_row(alu_row("alu to x5", 1, 5'd5, 32'h1234_5678, 5'd5, 32'h1234_5678));
        add_row(alu_row("write to x0", 1, 5'd0, 32'hdead_beef, 5'd0, 32'h0));
        add_row(alu_row("wd clear", 0, 5'd5, 32'hffff_0000, 5'd5, 32'h1234_5678));
        r = alu_row("fence.i", 0, 5'd6, 32'h0, 5'd5, 32'h1234_5678);
        r.fencei = 1'b1;
        add_row(r);
        add_row(csr_row("mtvec write", CSR_WRITE, CSR_MTVEC, 32'h8000_0100, 0, CSR_MTVEC,
                        32'h8000_0100));
        add_row(csr_row("mtvec set", CSR_SET, CSR_MTVEC, 32'h0000_000c, 0, CSR_MTVEC,
                        32'h8000_010c));
        add_row(csr_row("mtvec clear", CSR_CLEAR, CSR_MTVEC, 32'h8000_0000, 0, CSR_MTVEC,
                        32'h0000_010c));
        add_row(csr_row("mstatus write", CSR_WRITE, CSR_MSTATUS, 32'h0000_1888, 0,
                        CSR_MSTATUS, 32'h0000_1888));
        add_row(csr_row("mstatus set", CSR_SET, CSR_MSTATUS, 32'h0000_0003, 0,
                        CSR_MSTATUS, 32'h0000_188b));
        add_row(csr_row("mstatus clear", CSR_CLEAR, CSR_MSTATUS, 32'h0000_0880, 0,
                        CSR_MSTATUS, 32'h0000_100b));
        add_row(csr_row("ecall cause", CSR_ECALL, 12'h0, 32'h0, 32'h0000_000b, CSR_MCAUSE,
                        32'h0000_000b));
        add_row(csr_row("unknown csr", CSR_WRITE, 12'h7c0, 32'h5a5a_5a5a, 0, 12'h7c0, 32'h0));
        r = alu_row("ebreak", 1, 5'd7, 32'h0000_0042, 5'd7, 32'h0000_0042);
        r.ebreak = 1'b1;
        add_row(r);
        // byte lanes of LOAD_WORD are 01, c3, 7f, 8a from offset 0 up
        add_row(load_row("lb off0", LOAD_LB, 32'h1000, LOAD_WORD, 5'd10, 32'h0000_0001));
        add_row(load_row("lb off1", LOAD_LB, 32'h1001, LOAD_WORD, 5'd10, 32'hffff_ffc3));
        add_row(load_row("lb off2", LOAD_LB, 32'h1002, LOAD_WORD, 5'd10, 32'h0000_007f));
        add_row(load_row("lb off3", LOAD_LB, 32'h1003, LOAD_WORD, 5'd10, 32'hffff_ff8a));
        add_row(load_row("lbu off0", LOAD_LBU, 32'h1000, LOAD_WORD, 5'd11, 32'h0000_0001));
        add_row(load_row("lbu off1", LOAD_LBU, 32'h1001, LOAD_WORD, 5'd11, 32'h0000_00c3));
        add_row(load_row("lbu off2", LOAD_LBU, 32'h1002, LOAD_WORD, 5'd11, 32'h0000_007f));
        add_row(load_row("lbu off3", LOAD_LBU, 32'h1003, LOAD_WORD, 5'd11, 32'h0000_008a));
        add_row(load_row("lh off0", LOAD_LH, 32'h1000, LOAD_WORD, 5'd12, 32'hffff_c301));
        add_row(load_row("lh off2", LOAD_LH, 32'h1002, LOAD_WORD, 5'd12, 32'hffff_8a7f));
        add_row(load_row("lhu off0", LOAD_LHU, 32'h1000, LOAD_WORD, 5'd13, 32'h0000_c301));
        add_row(load_row("lhu off2", LOAD_LHU, 32'h1002, LOAD_WORD, 5'd13, 32'h0000_8a7f));
        add_row(load_row("lw", LOAD_LW, 32'h1000, LOAD_WORD, 5'd14, LOAD_WORD));
    endtask

    task automatic compare_word(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
        if (act !== exp) begin
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
            data_errors = data_errors + 1;
        end
    endtask

    task automatic verify_flag(input string name, input string sig, input logic exp,
                               input logic act);
        if (act !== exp) begin
            $display("FAILED %s: %s expected %b, actual %b", name, sig, exp, act);
            ctrl_errors = ctrl_errors + 1;
        end
    endtask

    task automatic drive_idle();
        valid_i  <= 1'b0;
        ebreak_i <= 1'b0;
        fencei_i <= 1'b0;
    endtask

    // one valid cycle, two idle cycles, then read back
    task automatic apply_item(input row_t r);
        @(posedge clock);
        valid_i      <= 1'b1;
        wd_i         <= r.wd;
        wreg_i       <= r.wreg;
        alu_result_i <= r.alu;
        load_op_i    <= r.lop;
        mem_rdata_i  <= r.mem;
        csr_op_i     <= r.cop;
        csr_addr_i   <= r.caddr;
        csr_wdata_i  <= r.cwdata;
        csr_mcause_i <= r.cause;
        ebreak_i     <= r.ebreak;
        fencei_i     <= r.fencei;
        rs_addr_i    <= r.probe[4:0];
        csr_raddr_i  <= r.probe;
        @(posedge clock);
        drive_idle();
        @(negedge clock);
        verify_flag(r.name, "flush_o", 1'b0, flush_o);
        verify_flag(r.name, "halt_o", halt_exp, halt_o);
        @(posedge clock);
        @(negedge clock);
        if (r.ebreak) begin
            halt_exp = 1'b1;
        end
        verify_flag(r.name, "flush_o", r.fencei, flush_o);
        verify_flag(r.name, "halt_o", halt_exp, halt_o);
        @(posedge clock);
        @(negedge clock);
        verify_flag(r.name, "flush_o", 1'b0, flush_o);
        verify_flag(r.name, "halt_o", halt_exp, halt_o);
        compare_word(r.name, r.exp, r.probe_csr ? csr_rdata_o : rs_data_o);
    endtask

    task automatic random_loads();
        row_t        r;
        load_op_t    op;
        logic [31:0] data;
        logic [1:0]  off;
        logic [4:0]  wreg;
        for (int i = 0; i < NUM_RAND; i++) begin
            lcg_state = next_random(lcg_state);
            data = lcg_state;
            lcg_state = next_random(lcg_state);
            case ((lcg_state >> 20) % 5)
                0:       op = LOAD_LB;
                1:       op = LOAD_LBU;
                2:       op = LOAD_LH;
                3:       op = LOAD_LHU;
                default: op = LOAD_LW;
            endcase
            // keep halfword and word accesses aligned, offsets from the upper bits
            if (op == LOAD_LW) begin
                off = 2'b00;
            end else if (op == LOAD_LH || op == LOAD_LHU) begin
                off = {lcg_state[29], 1'b0};
            end else begin
                off = lcg_state[29:28];
            end
            wreg = 5'(1 + (lcg_state >> 8) % 31);
            r = load_row($sformatf("random load %0d", i), op, {lcg_state[31:2], off}, data,
                         wreg, extend_load(op, data, off));
            apply_item(r);
        end
    endtask

    task automatic back_to_back_writes();
        logic [31:0] values [3];
        values[0] = 32'h1111_aaaa;
        values[1] = 32'h2222_bbbb;
        values[2] = 32'h3333_cccc;
        for (int k = 0; k < 3; k++) begin
            @(posedge clock);
            valid_i      <= 1'b1;
            wd_i         <= 1'b1;
            wreg_i       <= 5'(20 + k);
            alu_result_i <= values[k];
            load_op_i    <= LOAD_NONE;
            csr_op_i     <= CSR_NONE;
        end
        @(posedge clock);
        drive_idle();
        repeat (2) @(posedge clock);
        for (int k = 0; k < 3; k++) begin
            @(posedge clock);
            rs_addr_i <= 5'(20 + k);
            @(negedge clock);
            compare_word($sformatf("back-to-back x%0d", 20 + k), values[k], rs_data_o);
        end
    endtask

    task automatic reset_recheck();
        @(posedge clock);
        reset <= 1'b1;
        repeat (2) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        verify_flag("second reset", "halt_o", 1'b0, halt_o);
        verify_flag("second reset", "flush_o", 1'b0, flush_o);
        compare_word("second reset x22", 32'h0, rs_data_o);
    endtask

    initial begin
        reset        = 1'b1;
        valid_i      = 1'b0;
        wd_i         = 1'b0;
        wreg_i       = '0;
        alu_result_i = '0;
        load_op_i    = LOAD_NONE;
        mem_rdata_i  = '0;
        csr_op_i     = CSR_NONE;
        csr_addr_i   = '0;
        csr_wdata_i  = '0;
        csr_mcause_i = '0;
        ebreak_i     = 1'b0;
        fencei_i     = 1'b0;
        rs_addr_i    = '0;
        csr_raddr_i  = '0;
        row_count    = 0;
        data_errors  = 0;
        ctrl_errors  = 0;
        cycle_count  = 0;
        halt_exp     = 1'b0;
        lcg_state    = 32'h8be7eed7;
        build_table();
        repeat (8) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        verify_flag("after reset", "halt_o", 1'b0, halt_o);
        verify_flag("after reset", "flush_o", 1'b0, flush_o);
        for (int i = 0; i < row_count; i++) begin
            apply_item(rows[i]);
        end
        random_loads();
        back_to_back_writes();
        reset_recheck();
        $display("errors: %0d data, %0d control", data_errors, ctrl_errors);
        if (data_errors == 0 && ctrl_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- src.f
design/core_pkg.sv
design/wb_bus_if.sv
design/csr_write_if.sv
design/mem_result_stage.sv
design/writeback_stage.sv
design/int_regfile.sv
design/csr_file.sv
design/core_backend_top.sv
tests/core_backend_tb.sv
